//--- fpa_subsys.f
+incdir+hdl
hdl/fpa_ctl_pkg.sv
hdl/fpa_data_pkg.sv
hdl/fpa_treg.sv
hdl/fpa_mreg.sv
hdl/fpa_arith.sv
hdl/fpa_top.sv
dv/fpa_checker.sv
dv/fpa_tb.sv

//--- run.sh
#!/bin/sh
# builds the mantissa datapath testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module fpa_tb \
	-f fpa_subsys.f \
	--Mdir obj_dir -o fpa_sim

./obj_dir/fpa_sim | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- dv/fpa_tb.sv
// testbench top for the mantissa datapath, seeded random stimulus against a shadow register model
`timescale 1ns/1ps
`default_nettype none

module fpa_tb
	import fpa_ctl_pkg::*;
	import fpa_data_pkg::*;
();

	// test lengths in cycles
	localparam int N_WORD = 8;
	localparam int N_ARITH = 60;
	localparam int N_SHIFT = 200;
	localparam int N_CSH = 12;
	localparam int N_FLAG = 40;
	localparam int LIMIT = 3 + 4 + 4 * N_WORD + 4 * N_ARITH + N_SHIFT
		+ 10 * N_CSH + N_FLAG + 2 + 50;

	logic clk_sys;
	logic _0_t;
	word_t w;
	shift_t t_mode, m_mode;
	logic t_en, m_en, t_ext_in, m_ext_in, c_load, c_shift;
	aluop_t alu_op;
	logic carry_in;
	ksel_t k_sel;
	zpsel_t zp_sel;
	logic zp_clear;
	logic [0:7] d;
	logic z_f, m_f, v_f, c_f;
	word_t zp;
	logic t_0_1, t_2_7, t_8_15, t_16_23, t_24_31, t_32_39;
	logic t_ext, t0, t1, t16, t39, m_ext, m0, m39;
	logic c0, c39, c0_eq_c1, t0_eq_c0, t0_neq_t1, t0_neq_t_ext;
	logic cy0, cy16, cy32;

	// shadow registers
	mant_ext_t mt, mm;
	mant_t mc;
	// model outputs
	mant_t c_eff, e_sum, e_k;
	logic [40:0] full;
	logic [24:0] lo24;
	logic [8:0] lo8;
	word_t e_zp;
	logic [0:2] e_cy, a_cy;
	logic [0:5] e_zg, a_zg;
	logic [0:13] e_tap, a_tap;

	logic check_en, done, report_done;
	logic [2:0] test_id;
	int err_total;
	int cycles = 0;
	integer seed;
	logic [31:0] r;

	fpa_top fpa_top_inst (.*);

	assign a_cy = {cy0, cy16, cy32};
	assign a_zg = {t_0_1, t_2_7, t_8_15, t_16_23, t_24_31, t_32_39};
	assign a_tap = {t_ext, t0, t1, t16, t39, m_ext, m0, m39,
		c0, c39, c0_eq_c1, t0_eq_c0, t0_neq_t1, t0_neq_t_ext};

	fpa_checker fpa_checker_inst (
		.clk_sys     (clk_sys),
		.check_en    (check_en),
		.test_id     (test_id),
		.done        (done),
		.act_zp      (zp),
		.exp_zp      (e_zp),
		.act_cy      (a_cy),
		.exp_cy      (e_cy),
		.act_zg      (a_zg),
		.exp_zg      (e_zg),
		.act_tap     (a_tap),
		.exp_tap     (e_tap),
		.err_total   (err_total),
		.report_done (report_done)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// whole 40-bit add, carries from the low 8 and low 24 bits separately
	always_comb begin
		c_eff = (alu_op == ALU_SUB) ? ~mc : mc;
		full = {1'b0, mt[0:39]} + {1'b0, c_eff} + 41'(carry_in);
		lo24 = {1'b0, mt[16:39]} + {1'b0, c_eff[16:39]} + 25'(carry_in);
		lo8 = {1'b0, mt[32:39]} + {1'b0, c_eff[32:39]} + 9'(carry_in);
		e_sum = full[39:0];
		e_cy = {full[40], lo24[24], lo8[8]};
		case (k_sel)
			K_SUM:  e_k = e_sum;
			K_M:    e_k = mm[0:39];
			K_WORD: e_k = {w, w, w[0:7]};
			K_ZERO: e_k = '0;
		endcase
		if (zp_clear) e_zp = '0;
		else if (zp_sel == ZP_T_HI) e_zp = mt[0:15];
		else if (zp_sel == ZP_T_MID) e_zp = mt[16:31];
		else if (zp_sel == ZP_T_LO) e_zp = {mt[32:39], d};
		else e_zp = {z_f, m_f, v_f, c_f, 12'h000};
		e_zg = {|mt[0:1], |mt[2:7], |mt[8:15], |mt[16:23], |mt[24:31], |mt[32:39]};
		e_tap = {mt[-1], mt[0], mt[1], mt[16], mt[39], mm[-1], mm[0], mm[39],
			mc[0], mc[39], mc[0] == mc[1], mt[0] == mc[0], mt[0] != mt[1], mt[0] != mt[-1]};
	end

	// register rules applied at each rising edge
	always @(posedge clk_sys or posedge _0_t) begin
		if (_0_t) begin
			mt <= '0;
			mm <= '0;
			mc <= '0;
		end else begin
			if (t_en) begin
				case (t_mode)
					SH_HOLD:  mt[0:39] <= mt[0:39];
					SH_RIGHT: mt[0:39] <= mt[-1:38];
					SH_LEFT:  mt[0:39] <= {mt[1:39], mm[-1]};
					SH_LOAD:  mt[0:39] <= e_k;
				endcase
				mt[-1] <= t_ext_in;
			end
			if (m_en) begin
				case (m_mode)
					SH_HOLD:  mm[0:39] <= mm[0:39];
					SH_RIGHT: mm[0:39] <= mm[-1:38];
					SH_LEFT:  mm[0:39] <= {mm[1:39], 1'b0};
					SH_LOAD:  mm[0:39] <= mt[0:39];
				endcase
				mm[-1] <= m_ext_in;
			end
			if (c_load) mc <= mt[0:39];
			else if (c_shift) mc <= {mc[0], mc[0:38]};
		end
	end

	// run limit from the summed test lengths
	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > LIMIT) begin
			$display("timeout: run passed %0d cycles without finishing", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic logic [31:0] rnd();
		rnd = $random(seed);
	endfunction

	// strobes off, registers hold
	task automatic idle();
		t_en = 1'b0;
		m_en = 1'b0;
		c_load = 1'b0;
		c_shift = 1'b0;
		zp_clear = 1'b0;
		t_mode = SH_HOLD;
		m_mode = SH_HOLD;
		k_sel = K_ZERO;
	endtask

	// T takes the replicated word on the next rise
	task automatic load_t_word(input word_t v, input logic ext);
		@(negedge clk_sys);
		idle();
		w = v;
		k_sel = K_WORD;
		t_mode = SH_LOAD;
		t_en = 1'b1;
		t_ext_in = ext;
	endtask

	initial begin
		seed = 32'h4c96_d886;
		idle();
		w = '0;
		t_ext_in = 1'b0;
		m_ext_in = 1'b0;
		alu_op = ALU_ADD;
		carry_in = 1'b0;
		zp_sel = ZP_T_HI;
		d = '0;
		{z_f, m_f, v_f, c_f} = 4'b0000;
		check_en = 1'b0;
		done = 1'b0;
		test_id = 3'd0;
		_0_t = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		_0_t = 1'b0;
		check_en = 1'b1;
		test_id = 3'd1;

		// every readout slice straight after reset
		for (int i = 0; i < 4; i++) begin
			if (i > 0) @(negedge clk_sys);
			r = rnd();
			zp_sel = zpsel_t'(i[1:0]);
			{z_f, m_f, v_f, c_f} = r[3:0];
			d = r[15:8];
		end

		@(negedge clk_sys);
		test_id = 3'd2;
		repeat (N_WORD) begin
			r = rnd();
			load_t_word(r[15:0], r[16]);
			for (int s = 0; s < 3; s++) begin
				@(negedge clk_sys);
				idle();
				zp_sel = zpsel_t'(s[1:0]);
				d = r[31:24];
			end
		end

		test_id = 3'd3;
		repeat (N_ARITH) begin
			r = rnd();
			load_t_word(r[15:0], r[16]);
			@(negedge clk_sys);
			idle();
			c_load = 1'b1;
			load_t_word(r[31:16], r[17]);
			@(negedge clk_sys);
			idle();
			r = rnd();
			alu_op = aluop_t'(r[0]);
			carry_in = r[1];
			zp_sel = zpsel_t'({1'b0, r[2]});
			// sum back into T
			k_sel = K_SUM;
			t_mode = SH_LOAD;
			t_en = 1'b1;
		end

		test_id = 3'd4;
		repeat (N_SHIFT) begin
			@(negedge clk_sys);
			idle();
			r = rnd();
			t_en = r[0];
			m_en = r[1];
			t_mode = shift_t'(r[3:2]);
			m_mode = shift_t'(r[5:4]);
			t_ext_in = r[6];
			m_ext_in = r[7];
			k_sel = ksel_t'(r[9:8]);
			zp_sel = zpsel_t'(r[11:10]);
			alu_op = aluop_t'(r[12]);
			carry_in = r[13];
			w = r[31:16];
		end

		test_id = 3'd5;
		repeat (N_CSH) begin
			r = rnd();
			load_t_word(r[15:0], r[16]);
			@(negedge clk_sys);
			idle();
			c_load = 1'b1;
			repeat (8) begin
				@(negedge clk_sys);
				idle();
				r = rnd();
				c_shift = 1'b1;
				// occasional new T for the sign compare
				w = r[31:16];
				k_sel = K_WORD;
				t_mode = SH_LOAD;
				t_en = r[0];
			end
		end

		test_id = 3'd6;
		repeat (N_FLAG) begin
			@(negedge clk_sys);
			idle();
			r = rnd();
			{z_f, m_f, v_f, c_f} = r[3:0];
			zp_sel = ZP_FLAGS;
			zp_clear = r[4];
		end

		@(negedge clk_sys);
		idle();
		check_en = 1'b0;
		test_id = 3'd0;
		done = 1'b1;
		wait (report_done);
		if (err_total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/fpa_checker.sv
// testbench checker, compares DUT outputs with the model after each falling edge and keeps counts
`timescale 1ns/1ps
`default_nettype none

module fpa_checker
	import fpa_data_pkg::*;
(
	input  logic        clk_sys,
	// compare strobe and current test number, 0 is none
	input  logic        check_en,
	input  logic [2:0]  test_id,
	input  logic        done,
	input  word_t       act_zp,
	input  word_t       exp_zp,
	// cy0, cy16, cy32
	input  logic [0:2]  act_cy,
	input  logic [0:2]  exp_cy,
	// six zero groups of T
	input  logic [0:5]  act_zg,
	input  logic [0:5]  exp_zg,
	// single-bit taps and compares
	input  logic [0:13] act_tap,
	input  logic [0:13] exp_tap,
	output int          err_total,
	output logic        report_done
);

	string names [1:6] = '{"reset_state", "word_load", "add_sub",
		"shift_load", "c_shift", "flags_clear"};

	int test_checks = 0;
	int test_errs = 0;
	int n_tests = 0;
	int n_checks = 0;
	int errs = 0;
	logic reported = 1'b0;
	logic [2:0] cur_id = 3'd0;

	assign err_total = errs;
	assign report_done = reported;

	// one value against the model
	task automatic compare(input string sig, input logic [15:0] exp_v,
		input logic [15:0] act_v);
		test_checks++;
		n_checks++;
		if (act_v !== exp_v) begin
			test_errs++;
			errs++;
			$display("ERROR test=%s signal=%s expected=%h actual=%h",
				names[cur_id], sig, exp_v, act_v);
		end
	endtask

	// per-test summary line
	task automatic close_test();
		n_tests++;
		$display("test %0d %s finished: %0d checks, %0d errors",
			cur_id, names[cur_id], test_checks, test_errs);
		test_checks = 0;
		test_errs = 0;
	endtask

	// sample midway through the low phase
	// inputs changed at the falling edge, registers hold until the next rise
	always @(negedge clk_sys) begin
		#1;
		if (test_id != cur_id) begin
			if (cur_id != 3'd0) begin
				close_test();
			end
			cur_id = test_id;
		end
		if (check_en && cur_id != 3'd0) begin
			compare("zp", exp_zp, act_zp);
			compare("carries", 16'(exp_cy), 16'(act_cy));
			compare("zero_groups", 16'(exp_zg), 16'(act_zg));
			compare("taps", 16'(exp_tap), 16'(act_tap));
		end
		if (done && !reported) begin
			$display("tests run: %0d, checks: %0d, errors: %0d", n_tests, n_checks, errs);
			reported = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hdl/fpa_top.sv
// top level of the mantissa datapath, wires T, M and the arithmetic block to the pins
`timescale 1ns/1ps
`default_nettype none

`include "fpa_defs.svh"

module fpa_top
	import fpa_ctl_pkg::*;
	import fpa_data_pkg::*;
(
	input  logic       clk_sys,
	input  logic       _0_t,
	input  word_t      w,
	// register controls
	input  shift_t     t_mode,
	input  shift_t     m_mode,
	input  logic       t_en,
	input  logic       m_en,
	input  logic       t_ext_in,
	input  logic       m_ext_in,
	input  logic       c_load,
	input  logic       c_shift,
	// adder and buses
	input  aluop_t     alu_op,
	input  logic       carry_in,
	input  ksel_t      k_sel,
	input  zpsel_t     zp_sel,
	input  logic       zp_clear,
	input  logic [0:7] d,
	// flag word sources
	input  logic       z_f,
	input  logic       m_f,
	input  logic       v_f,
	input  logic       c_f,
	output word_t      zp,
	// zero groups of T
	output logic       t_0_1,
	output logic       t_2_7,
	output logic       t_8_15,
	output logic       t_16_23,
	output logic       t_24_31,
	output logic       t_32_39,
	// T taps
	output logic       t_ext,
	output logic       t0,
	output logic       t1,
	output logic       t16,
	output logic       t39,
	// M taps
	output logic       m_ext,
	output logic       m0,
	output logic       m39,
	// C taps and compares
	output logic       c0,
	output logic       c39,
	output logic       c0_eq_c1,
	output logic       t0_eq_c0,
	output logic       t0_neq_t1,
	output logic       t0_neq_t_ext,
	output logic       cy0,
	output logic       cy16,
	output logic       cy32
);

	mant_ext_t  t;
	mant_ext_t  m;
	mant_t      k;
	logic [0:5] zero_grp;

	fpa_treg fpa_treg_inst (
		.clk_sys      (clk_sys),
		._0_t         (_0_t),
		.en           (t_en),
		.mode         (t_mode),
		.ext_in       (t_ext_in),
		.k            (k),
		.m_ext        (m[-1]),
		.t            (t),
		.zero_grp     (zero_grp),
		.t0_neq_t1    (t0_neq_t1),
		.t0_neq_t_ext (t0_neq_t_ext)
	);

	fpa_mreg fpa_mreg_inst (
		.clk_sys (clk_sys),
		._0_t    (_0_t),
		.en      (m_en),
		.mode    (m_mode),
		.ext_in  (m_ext_in),
		.t       (t[0:`FPA_MANT_W-1]),
		.m       (m)
	);

	fpa_arith fpa_arith_inst (
		.clk_sys  (clk_sys),
		._0_t     (_0_t),
		.t        (t),
		.m        (m),
		.w        (w),
		.c_load   (c_load),
		.c_shift  (c_shift),
		.alu_op   (alu_op),
		.carry_in (carry_in),
		.k_sel    (k_sel),
		.zp_sel   (zp_sel),
		.zp_clear (zp_clear),
		.d        (d),
		.flags    ({z_f, m_f, v_f, c_f}),
		.k        (k),
		.zp       (zp),
		.cy0      (cy0),
		.cy16     (cy16),
		.cy32     (cy32),
		.c0       (c0),
		.c39      (c39),
		.c0_eq_c1 (c0_eq_c1),
		.t0_eq_c0 (t0_eq_c0)
	);

	// zero groups out to the pins
	assign t_0_1 = zero_grp[0];
	assign t_2_7 = zero_grp[1];
	assign t_8_15 = zero_grp[2];
	assign t_16_23 = zero_grp[3];
	assign t_24_31 = zero_grp[4];
	assign t_32_39 = zero_grp[5];

	// single-bit taps
	assign t_ext = t[-1];
	assign t0 = t[0];
	assign t1 = t[1];
	assign t16 = t[`FPA_SEG0];
	assign t39 = t[`FPA_MANT_W-1];
	assign m_ext = m[-1];
	assign m0 = m[0];
	assign m39 = m[`FPA_MANT_W-1];

endmodule

`default_nettype wire

//--- hdl/fpa_arith.sv
// C operand register, segmented adder, K bus select and ZP readout; used by fpa_top
`timescale 1ns/1ps
`default_nettype none

`include "fpa_defs.svh"

module fpa_arith
	import fpa_ctl_pkg::*;
	import fpa_data_pkg::*;
(
	input  logic      clk_sys,
	input  logic      _0_t,
	input  mant_ext_t t,
	input  mant_ext_t m,
	input  word_t     w,
	// C control, load wins over shift
	input  logic      c_load,
	input  logic      c_shift,
	input  aluop_t    alu_op,
	input  logic      carry_in,
	input  ksel_t     k_sel,
	input  zpsel_t    zp_sel,
	input  logic      zp_clear,
	input  logic [0:7] d,
	// z, m, v, c in that order
	input  logic [0:3] flags,
	output mant_t     k,
	output word_t     zp,
	output logic      cy0,
	output logic      cy16,
	output logic      cy32,
	output logic      c0,
	output logic      c39,
	output logic      c0_eq_c1,
	output logic      t0_eq_c0
);

	localparam int LSB = `FPA_MANT_W - 1;
	localparam int S0 = `FPA_SEG0;
	localparam int S1 = `FPA_SEG1;
	localparam int LO_W = `FPA_LO_W;
	localparam int MID_W = `FPA_SEG1 - `FPA_SEG0;
	localparam int HI_W = `FPA_SEG0;
	// short tail of the replicated word
	localparam int TAIL_W = `FPA_MANT_W - 2 * `FPA_WORD_W;

	mant_t c;
	mant_t c_op;
	mant_t sum;
	// segment results, carry out at index 0
	logic [0:LO_W]  lo_r;
	logic [0:MID_W] mid_r;
	logic [0:HI_W]  hi_r;

	// C takes T, or shifts right keeping its sign
	always_ff @(posedge clk_sys or posedge _0_t) begin
		if (_0_t) begin
			c <= '0;
		end else if (c_load) begin
			c <= t[0:LSB];
		end else if (c_shift) begin
			c <= {c[0], c[0:LSB-1]};
		end
	end

	// subtract adds the ones complement
	// caller supplies carry_in for the +1
	assign c_op = (alu_op == ALU_SUB) ? ~c : c;

	// low byte first, carry ripples up
	assign lo_r = {1'b0, t[S1:LSB]} + {1'b0, c_op[S1:LSB]} + (LO_W + 1)'(carry_in);
	assign mid_r = {1'b0, t[S0:S1-1]} + {1'b0, c_op[S0:S1-1]} + (MID_W + 1)'(lo_r[0]);
	assign hi_r = {1'b0, t[0:S0-1]} + {1'b0, c_op[0:S0-1]} + (HI_W + 1)'(mid_r[0]);

	assign sum = {hi_r[1:HI_W], mid_r[1:MID_W], lo_r[1:LO_W]};
	// carries out of bits 32, 16 and 0
	assign cy32 = lo_r[0];
	assign cy16 = mid_r[0];
	assign cy0 = hi_r[0];

	// k bus into T
	always_comb begin
		case (k_sel)
			K_SUM:   k = sum;
			K_M:     k = m[0:LSB];
			// w repeated, cut to the mantissa width
			K_WORD:  k = {w, w, w[0:TAIL_W-1]};
			default: k = '0;
		endcase
	end

	// zp readout, clear overrides the select
	always_comb begin
		if (zp_clear) begin
			zp = '0;
		end else begin
			case (zp_sel)
				ZP_T_HI:  zp = t[0:S0-1];
				ZP_T_MID: zp = t[S0:S1-1];
				ZP_T_LO:  zp = {t[S1:LSB], d};
				default:  zp = {flags, {(`FPA_WORD_W - 4){1'b0}}};
			endcase
		end
	end

	// C status
	assign c0 = c[0];
	assign c39 = c[LSB];
	assign c0_eq_c1 = c[0] == c[1];
	// sign agreement of T and C
	assign t0_eq_c0 = t[0] == c[0];

	// sequencer never asks for both C operations at once
	a_c_ops_exclusive: assert property (
		@(posedge clk_sys) disable iff (_0_t)
		!(c_load && c_shift)
	) else $error("fpa_arith: c_load and c_shift both high");

endmodule

`default_nettype wire

//--- hdl/fpa_mreg.sv
// M multiplier/quotient register, loaded from T or shifted one place per enabled cycle; used by fpa_top
`timescale 1ns/1ps
`default_nettype none

module fpa_mreg
	import fpa_ctl_pkg::*;
	import fpa_data_pkg::*;
(
	input  logic      clk_sys,
	input  logic      _0_t,
	input  logic      en,
	input  shift_t    mode,
	// serial bit into the extension position
	input  logic      ext_in,
	// load source, T without its extension
	input  mant_t     t,
	output mant_ext_t m
);

	localparam int MSB = 0;
	localparam int LSB = $bits(mant_t) - 1;

	// shared clear with T and C
	always_ff @(posedge clk_sys or posedge _0_t) begin
		if (_0_t) begin
			m <= '0;
		end else if (en) begin
			case (mode)
				SH_HOLD: begin
					m[MSB:LSB] <= m[MSB:LSB];
				end
				SH_RIGHT: begin
					// quotient bits walk down
					// extension moves into bit 0
					m[MSB:LSB] <= m[-1:LSB-1];
				end
				SH_LEFT: begin
					// zero enters at bit 39
					m[MSB:LSB] <= {m[MSB+1:LSB], 1'b0};
				end
				SH_LOAD: begin
					m[MSB:LSB] <= t;
				end
				default: begin
					m[MSB:LSB] <= m[MSB:LSB];
				end
			endcase
			// extension reloads whenever M is clocked
			m[-1] <= ext_in;
		end
	end

	// M is part of the multiply/divide state
	// an undefined mode or serial bit on a clocked step corrupts it
	a_step_defined: assert property (
		@(posedge clk_sys) disable iff (_0_t)
		en |-> !$isunknown({mode, ext_in})
	) else $error("fpa_mreg: mode or ext_in unknown while en is high");

endmodule

`default_nettype wire

//--- hdl/fpa_treg.sv
// T accumulator register with extension bit, zero-detect groups and sign compares; used by fpa_top
`timescale 1ns/1ps
`default_nettype none

`include "fpa_defs.svh"

module fpa_treg
	import fpa_ctl_pkg::*;
	import fpa_data_pkg::*;
(
	input  logic      clk_sys,
	input  logic      _0_t,
	// update strobe and mode
	input  logic      en,
	input  shift_t    mode,
	// serial bit for the extension position
	input  logic      ext_in,
	// parallel load source
	input  mant_t     k,
	// M extension bit, enters bit 39 on a left shift
	input  logic      m_ext,
	output mant_ext_t t,
	// or-reductions, index 0 is the t_0_1 group
	output logic [0:5] zero_grp,
	output logic      t0_neq_t1,
	output logic      t0_neq_t_ext
);

	localparam int MSB = 0;
	localparam int LSB = `FPA_MANT_W - 1;
	// middle and low segment starts
	localparam int MID = `FPA_SEG0;
	localparam int LOW = `FPA_SEG1;
	// split point inside the middle segment
	localparam int MID2 = `FPA_SEG0 + 8;

	// one enable for the whole register
	always_ff @(posedge clk_sys or posedge _0_t) begin
		if (_0_t) begin
			t <= '0;
		end else if (en) begin
			case (mode)
				SH_HOLD: begin
					t[MSB:LSB] <= t[MSB:LSB];
				end
				SH_RIGHT: begin
					// extension bit drops into bit 0
					t[MSB:LSB] <= t[-1:LSB-1];
				end
				SH_LEFT: begin
					// M's extension bit fills the low end
					t[MSB:LSB] <= {t[MSB+1:LSB], m_ext};
				end
				SH_LOAD: begin
					t[MSB:LSB] <= k;
				end
				default: begin
					t[MSB:LSB] <= t[MSB:LSB];
				end
			endcase
			// extension reloads on every enabled edge
			t[-1] <= ext_in;
		end
	end

	// zero-detect groups
	// sign pair
	assign zero_grp[0] = |t[MSB:MSB+1];
	// rest of the first byte
	assign zero_grp[1] = |t[MSB+2:MSB+7];
	// second byte of the high segment
	assign zero_grp[2] = |t[MSB+8:MID-1];
	// middle segment, two bytes
	assign zero_grp[3] = |t[MID:MID2-1];
	assign zero_grp[4] = |t[MID2:LOW-1];
	// low byte
	assign zero_grp[5] = |t[LOW:LSB];

	// normalization checks
	// sign against first fraction bit
	assign t0_neq_t1 = t[MSB] != t[MSB+1];
	// sign against extension, overflow out of bit 0
	assign t0_neq_t_ext = t[MSB] != t[-1];

	// an enabled cycle needs a defined mode
	// otherwise T goes to x and the next sum is lost
	a_mode_known: assert property (
		@(posedge clk_sys) disable iff (_0_t)
		en |-> !$isunknown(mode)
	) else $error("fpa_treg: mode unknown while en is high");

endmodule

`default_nettype wire

//--- hdl/fpa_data_pkg.sv
// data types of the mantissa datapath, imported wherever a mantissa or word is carried
`default_nettype none

`include "fpa_defs.svh"

package fpa_data_pkg;

	// plain mantissa
	// index 0 is the msb
	typedef logic [0:`FPA_MANT_W-1] mant_t;

	// mantissa with the sign-extension bit
	// extension sits at index -1, above the msb
	typedef logic [-1:`FPA_MANT_W-1] mant_ext_t;

	// 16-bit word, same big-endian numbering
	// used for w and zp
	typedef logic [0:`FPA_WORD_W-1] word_t;

endpackage

`default_nettype wire

//--- hdl/fpa_ctl_pkg.sv
// control encodings for the mantissa datapath, imported by the blocks that decode them
`default_nettype none

package fpa_ctl_pkg;

	// source of the k bus that loads into T
	// encoding follows the lkb/f9 pair
	typedef enum logic [1:0] {
		K_SUM  = 2'd0,
		K_M    = 2'd1,
		K_WORD = 2'd2,
		K_ZERO = 2'd3
	} ksel_t;

	// register update mode, shared by T and M
	typedef enum logic [1:0] {
		SH_HOLD  = 2'd0,
		SH_RIGHT = 2'd1,
		SH_LEFT  = 2'd2,
		SH_LOAD  = 2'd3
	} shift_t;

	// adder operation, subtract inverts C
	typedef enum logic {
		ALU_ADD = 1'b0,
		ALU_SUB = 1'b1
	} aluop_t;

	// zp readout slice
	typedef enum logic [1:0] {
		ZP_T_HI  = 2'd0,
		ZP_T_MID = 2'd1,
		ZP_T_LO  = 2'd2,
		ZP_FLAGS = 2'd3
	} zpsel_t;

endpackage

`default_nettype wire

//--- hdl/fpa_defs.svh
// widths and segment boundaries of the mantissa datapath, included by packages and RTL
`ifndef FPA_DEFS_SVH
`define FPA_DEFS_SVH

// mantissa width in bits
// bit 0 is the most significant, big-endian like the hardware
`define FPA_MANT_W 40

// width of the input word w and the zp readout
`define FPA_WORD_W 16

// segment boundaries, counted from the msb
// bits 0..15 are the high segment
// bits 16..31 are the middle segment
`define FPA_SEG0 16

// bits 32..39 are the low byte
`define FPA_SEG1 32

// width of the low segment
`define FPA_LO_W (`FPA_MANT_W - `FPA_SEG1)

`endif
